//--- hw/dcache_pkg.sv
// one 64-bit word per line, 16-bit line addresses; four ways fixed by the 3-bit pseudo-LRU tree
package dcache_pkg;

  // way count is tied to the tree shape, not a parameter
  localparam int NUM_WAYS = 4;

  // processor line address, low bits select the set
  typedef logic [15:0] line_addr_t;

  // one data word, which is also one line
  typedef logic [63:0] word_t;

  // one-hot way vector
  typedef logic [NUM_WAYS-1:0] way_sel_t;

  // encoded way number
  typedef logic [1:0] way_idx_t;

  // full line address kept as tag so the set count can vary
  typedef struct packed {
    logic       valid;
    logic       dirty;
    line_addr_t addr;
    word_t      data;
  } cache_line_t;

  // controller states
  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_writeback,
    s_fetch,
    s_fill
  } ctrl_state_t;

endpackage

//--- hw/dcache_way.sv
// num_sets must be a power of two from 2 to 256; lookup and write share one address
module dcache_way
  import dcache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic        clock,
  input  logic        reset,
  input  line_addr_t  lookup_addr,
  input  logic        write,
  input  cache_line_t write_line,
  output logic        hit,
  output cache_line_t line
);

  localparam int set_bits = $clog2(num_sets);

  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;
  line_addr_t          addr_mem [num_sets];
  word_t               data_mem [num_sets];
  logic [set_bits-1:0] set_index;

  assign set_index = lookup_addr[set_bits-1:0];

  // state bits, cleared on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (write) begin
      valid_q[set_index] <= write_line.valid;
      dirty_q[set_index] <= write_line.dirty;
    end
  end

  // address and data storage
  always_ff @(posedge clock) begin
    if (write) begin
      addr_mem[set_index] <= write_line.addr;
      data_mem[set_index] <= write_line.data;
    end
  end

  // entry of the addressed set, used for hit data and as victim
  always_comb begin
    line.valid = valid_q[set_index];
    line.dirty = dirty_q[set_index];
    line.addr  = addr_mem[set_index];
    line.data  = data_mem[set_index];
  end

  // whole line address compared as tag
  assign hit = line.valid && (line.addr == lookup_addr);

endmodule

//--- hw/plru_tree.sv
// three bits per set for exactly four ways; all bits clear on reset so way 0 goes first
module plru_tree
  import dcache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [$clog2(num_sets)-1:0] set_index,
  input  logic                        touch,
  input  way_idx_t                    touch_way,
  output way_idx_t                    victim
);

  // root picks the half, left covers ways 0/1, right covers ways 2/3
  logic [num_sets-1:0] root_q;
  logic [num_sets-1:0] left_q;
  logic [num_sets-1:0] right_q;
  logic                root_bit;
  logic                left_bit;
  logic                right_bit;

  assign root_bit  = root_q[set_index];
  assign left_bit  = left_q[set_index];
  assign right_bit = right_q[set_index];

  // follow the tree toward the least recently used way
  always_comb begin
    if (root_bit) begin
      victim = {1'b1, right_bit};
    end else begin
      victim = {1'b0, left_bit};
    end
  end

  // on access, bits along the path point away from the touched way
  always_ff @(posedge clock) begin
    if (reset) begin
      root_q  <= '0;
      left_q  <= '0;
      right_q <= '0;
    end else if (touch) begin
      root_q[set_index] <= ~touch_way[1];
      if (touch_way[1]) begin
        right_q[set_index] <= ~touch_way[0];
      end else begin
        left_q[set_index] <= ~touch_way[0];
      end
    end
  end

endmodule

//--- hw/dcache_array.sv
// write without fill goes to the hit way and is dropped on a miss; a line sits in one way only
module dcache_array
  import dcache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic        clock,
  input  logic        reset,
  input  line_addr_t  lookup_addr,
  input  logic        write,
  input  logic        fill,
  input  cache_line_t write_line,
  output logic        hit,
  output cache_line_t hit_line,
  output cache_line_t victim_line
);

  localparam int set_bits = $clog2(num_sets);

  way_sel_t            way_hit;
  way_sel_t            way_write;
  cache_line_t         way_line [NUM_WAYS];
  way_idx_t            hit_way;
  way_idx_t            victim_way;
  way_idx_t            touch_way;
  logic                touch;
  logic [set_bits-1:0] set_index;

  assign set_index = lookup_addr[set_bits-1:0];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    dcache_way #(
      .num_sets(num_sets)
    ) u_way (
      .clock      (clock),
      .reset      (reset),
      .lookup_addr(lookup_addr),
      .write      (way_write[w]),
      .write_line (write_line),
      .hit        (way_hit[w]),
      .line       (way_line[w])
    );
  end

  // encode the hitting way
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign hit         = |way_hit;
  assign hit_line    = way_line[hit_way];
  assign victim_line = way_line[victim_way];

  // fills replace the tree victim, hit writes update in place
  always_comb begin
    way_write = '0;
    if (write) begin
      if (fill) begin
        way_write[victim_way] = 1'b1;
      end else begin
        way_write = way_hit;
      end
    end
  end

  // every hit access and every fill refreshes the tree
  assign touch     = write & (fill | hit);
  assign touch_way = fill ? victim_way : hit_way;

  plru_tree #(
    .num_sets(num_sets)
  ) u_plru (
    .clock    (clock),
    .reset    (reset),
    .set_index(set_index),
    .touch    (touch),
    .touch_way(touch_way),
    .victim   (victim_way)
  );

endmodule

//--- hw/dcache_ctrl.sv
// one access in flight; req only while busy and resp_valid are low; memory serves one request
module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        req,
  input  logic        req_write,
  input  line_addr_t  req_addr,
  input  word_t       req_data,
  output logic        busy,
  output logic        resp_valid,
  output word_t       resp_data,
  output logic        resp_hit,
  output logic        mem_req,
  output logic        mem_write,
  output line_addr_t  mem_addr,
  output word_t       mem_wdata,
  input  logic        mem_done,
  input  word_t       mem_rdata,
  output line_addr_t  array_addr,
  output logic        array_write,
  output logic        array_fill,
  output cache_line_t array_line,
  input  logic        array_hit,
  input  cache_line_t hit_line,
  input  cache_line_t victim_line
);

  ctrl_state_t state;
  line_addr_t  addr_q;
  logic        write_q;
  word_t       wdata_q;
  word_t       fetch_q;
  logic        hit_update;
  logic        needs_wb;

  assign busy       = (state != s_idle);
  assign array_addr = addr_q;
  assign needs_wb   = victim_line.valid & victim_line.dirty;

  // hit write lands in the response cycle, so loads also refresh the tree
  assign hit_update  = resp_valid & resp_hit;
  assign array_fill  = (state == s_fill);
  assign array_write = array_fill | hit_update;

  // line written back into the array
  always_comb begin
    array_line.valid = 1'b1;
    array_line.addr  = addr_q;
    if (array_fill) begin
      array_line.dirty = write_q;
      array_line.data  = write_q ? wdata_q : fetch_q;
    end else begin
      array_line.dirty = hit_line.dirty | write_q;
      array_line.data  = write_q ? wdata_q : hit_line.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= s_idle;
      resp_valid <= 1'b0;
      mem_req    <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      mem_req    <= 1'b0;
      case (state)
        s_idle: begin
          if (req) begin
            state <= s_lookup;
          end
        end
        s_lookup: begin
          if (array_hit) begin
            state      <= s_idle;
            resp_valid <= 1'b1;
          end else begin
            // dirty victim goes out before the fetch
            state   <= needs_wb ? s_writeback : s_fetch;
            mem_req <= 1'b1;
          end
        end
        s_writeback: begin
          if (mem_done) begin
            state   <= s_fetch;
            mem_req <= 1'b1;
          end
        end
        s_fetch: begin
          if (mem_done) begin
            state <= s_fill;
          end
        end
        s_fill: begin
          state      <= s_idle;
          resp_valid <= 1'b1;
        end
        default: state <= s_idle;
      endcase
    end
  end

  // request, memory and response payload
  always_ff @(posedge clock) begin
    if (state == s_idle && req) begin
      addr_q  <= req_addr;
      write_q <= req_write;
      wdata_q <= req_data;
    end
    if (state == s_lookup) begin
      resp_hit  <= array_hit;
      resp_data <= write_q ? wdata_q : hit_line.data;
      mem_write <= needs_wb;
      mem_addr  <= needs_wb ? victim_line.addr : addr_q;
      mem_wdata <= victim_line.data;
    end
    if (state == s_writeback && mem_done) begin
      mem_write <= 1'b0;
      mem_addr  <= addr_q;
    end
    if (state == s_fetch && mem_done) begin
      fetch_q <= mem_rdata;
    end
    if (state == s_fill) begin
      resp_data <= array_line.data;
    end
  end

endmodule

//--- hw/dcache_top.sv
// write-allocate write-back cache, one word per line; num_sets a power of two from 2 to 256
module dcache_top
  import dcache_pkg::*;
#(
  parameter int num_sets = 16
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       req,
  input  logic       req_write,
  input  line_addr_t req_addr,
  input  word_t      req_data,
  output logic       busy,
  output logic       resp_valid,
  output word_t      resp_data,
  output logic       resp_hit,
  output logic       mem_req,
  output logic       mem_write,
  output line_addr_t mem_addr,
  output word_t      mem_wdata,
  input  logic       mem_done,
  input  word_t      mem_rdata
);

  line_addr_t  array_addr;
  logic        array_write;
  logic        array_fill;
  logic        array_hit;
  cache_line_t array_line;
  cache_line_t hit_line;
  cache_line_t victim_line;

  dcache_ctrl u_ctrl (
    .clock(clock), .reset(reset),
    .req(req), .req_write(req_write), .req_addr(req_addr), .req_data(req_data),
    .busy(busy), .resp_valid(resp_valid), .resp_data(resp_data), .resp_hit(resp_hit),
    .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_done(mem_done), .mem_rdata(mem_rdata),
    .array_addr(array_addr), .array_write(array_write), .array_fill(array_fill),
    .array_line(array_line), .array_hit(array_hit),
    .hit_line(hit_line), .victim_line(victim_line)
  );

  dcache_array #(
    .num_sets(num_sets)
  ) u_array (
    .clock(clock), .reset(reset),
    .lookup_addr(array_addr), .write(array_write), .fill(array_fill),
    .write_line(array_line), .hit(array_hit),
    .hit_line(hit_line), .victim_line(victim_line)
  );

endmodule

//--- tb/dcache_checker.sv
// protocol assertions on the dcache_top ports; bound to every dcache_top instance
module dcache_checker (
  input logic clock,
  input logic reset,
  input logic req,
  input logic busy,
  input logic resp_valid,
  input logic mem_req,
  input logic mem_done
);

  // a memory request is open from mem_req until mem_done
  logic mem_pending;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_pending <= 1'b0;
    end else if (mem_req) begin
      mem_pending <= 1'b1;
    end else if (mem_done) begin
      mem_pending <= 1'b0;
    end
  end

  resp_pulse: assert property (@(posedge clock) disable iff (reset)
    resp_valid |=> !resp_valid)
    else $error("resp_valid held longer than one cycle");

  mem_req_pulse: assert property (@(posedge clock) disable iff (reset)
    mem_req |=> !mem_req)
    else $error("mem_req held longer than one cycle");

  req_when_free: assert property (@(posedge clock) disable iff (reset)
    req |-> (!busy && !resp_valid))
    else $error("req raised while the cache was busy");

  one_mem_request: assert property (@(posedge clock) disable iff (reset)
    mem_req |-> !mem_pending)
    else $error("mem_req raised while a memory request was pending");

endmodule

bind dcache_top dcache_checker u_checker (.*);

//--- tb/dcache_tb.sv
// four sets so conflicts are easy; stimulus comes from tb/dcache_input.txt and op 2 ends the list
module dcache_tb
  import dcache_pkg::*;
;

  localparam int max_entries = 64;
  localparam int fields = 5;
  localparam int sets = 4;

  logic       clock;
  logic       reset;
  logic       req;
  logic       req_write;
  line_addr_t req_addr;
  word_t      req_data;
  logic       busy;
  logic       resp_valid;
  word_t      resp_data;
  logic       resp_hit;
  logic       mem_req;
  logic       mem_write;
  line_addr_t mem_addr;
  word_t      mem_wdata;
  logic       mem_done;
  word_t      mem_rdata;

  word_t      stim [max_entries*fields];
  word_t      shadow [line_addr_t];
  word_t      store_rec [line_addr_t];
  int         value_errors;
  int         other_errors;
  int         write_count;
  int         cycle_count;
  int         timeout_limit;
  logic       mem_busy;
  logic [3:0] mem_wait;
  logic       mem_is_read;
  line_addr_t mem_addr_q;
  logic [15:0] lfsr;

  // expected contents per set, tree bits kept as {root, left, right}
  line_addr_t          ref_addr [sets][NUM_WAYS];
  logic [NUM_WAYS-1:0] ref_valid [sets];
  logic [2:0]          ref_tree [sets];

  dcache_top #(
    .num_sets(sets)
  ) dut (
    .clock(clock), .reset(reset),
    .req(req), .req_write(req_write), .req_addr(req_addr), .req_data(req_data),
    .busy(busy), .resp_valid(resp_valid), .resp_data(resp_data), .resp_hit(resp_hit),
    .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_done(mem_done), .mem_rdata(mem_rdata)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  // preload value built from the whole address
  function automatic word_t mem_pattern(line_addr_t addr);
    return {addr, ~addr, addr, ~addr};
  endfunction

  function automatic logic [15:0] lfsr_step(logic [15:0] value);
    return value[0] ? ((value >> 1) ^ 16'hb400) : (value >> 1);
  endfunction

  task automatic compare(string name, word_t got, word_t expected);
    if (got !== expected) begin
      $display("error %s got %h expected %h", name, got, expected);
      value_errors++;
    end
  endtask

  // expected hit or miss, then the model takes the access
  task automatic predict_access(line_addr_t addr, output logic hit);
    int set_idx;
    int way;
    set_idx = int'(addr) % sets;
    hit     = 1'b0;
    way     = 0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_valid[set_idx][w] && ref_addr[set_idx][w] == addr) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // root selects the half and the leaf selects the way in it
      way = ref_tree[set_idx][2] ? 2 + int'(ref_tree[set_idx][0]) : int'(ref_tree[set_idx][1]);
      ref_valid[set_idx][way] = 1'b1;
      ref_addr[set_idx][way]  = addr;
    end
    // path bits point away from the accessed way
    ref_tree[set_idx][2] = (way < 2);
    if (way < 2) begin
      ref_tree[set_idx][1] = (way == 0);
    end else begin
      ref_tree[set_idx][0] = (way == 2);
    end
  endtask

  // memory model answering after 1 to 8 cycles
  always @(posedge clock) begin
    logic [2:0] bits;
    mem_done <= 1'b0;
    if (reset) begin
      mem_busy <= 1'b0;
    end else if (mem_req) begin
      bits = '0;
      for (int i = 0; i < 3; i++) begin
        lfsr = lfsr_step(lfsr);
        bits = {bits[1:0], lfsr[0]};
      end
      mem_busy    <= 1'b1;
      mem_wait    <= {1'b0, bits} + 4'd1;
      mem_is_read <= !mem_write;
      mem_addr_q  <= mem_addr;
      if (mem_write) begin
        write_count++;
        if (store_rec.exists(mem_addr)) begin
          compare("mem_wdata", mem_wdata, store_rec[mem_addr]);
        end else begin
          $display("writeback of address %h that was never stored", mem_addr);
          other_errors++;
        end
        shadow[mem_addr] = mem_wdata;
      end
    end else if (mem_busy) begin
      if (mem_wait == 4'd1) begin
        mem_done <= 1'b1;
        mem_busy <= 1'b0;
        if (mem_is_read) begin
          mem_rdata <= shadow.exists(mem_addr_q) ? shadow[mem_addr_q] : mem_pattern(mem_addr_q);
        end
      end else begin
        mem_wait <= mem_wait - 4'd1;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles waiting for the cache", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic access(logic write, line_addr_t addr, word_t data, word_t expected);
    int   cycles;
    logic exp_hit;
    cycles = 0;
    predict_access(addr, exp_hit);
    @(posedge clock);
    req       <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_data  <= data;
    if (write) begin
      store_rec[addr] = data;
    end
    forever begin
      @(posedge clock);
      req <= 1'b0;
      cycles++;
      @(negedge clock);
      if (resp_valid) begin
        break;
      end
      compare("busy", word_t'(busy), 64'd1);
    end
    compare("resp_data", resp_data, expected);
    compare("resp_hit", word_t'(resp_hit), word_t'(exp_hit));
    if (exp_hit) begin
      compare("hit_latency", word_t'(cycles), 64'd2);
    end
  endtask

  initial begin
    int entries;
    int wb_expected;
    req          = 1'b0;
    req_write    = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    mem_done     = 1'b0;
    mem_rdata    = '0;
    reset        = 1'b1;
    value_errors = 0;
    other_errors = 0;
    write_count  = 0;
    cycle_count  = 0;
    lfsr         = 16'd16765;
    entries      = 0;
    wb_expected  = 0;
    for (int s = 0; s < sets; s++) begin
      ref_valid[s] = '0;
      ref_tree[s]  = '0;
    end
    $readmemh("tb/dcache_input.txt", stim);
    while (entries < max_entries && stim[entries*fields] !== 64'd2) begin
      entries++;
    end
    timeout_limit = 16 + entries * 30;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < entries; i++) begin
      access(stim[i*fields][0], line_addr_t'(stim[i*fields+1]),
             stim[i*fields+2], stim[i*fields+3]);
      wb_expected += int'(stim[i*fields+4][0]);
    end
    repeat (4) @(posedge clock);
    compare("write_count", word_t'(write_count), word_t'(wb_expected));
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- all.f
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/plru_tree.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dcache_tb -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- tb/dcache_input.txt
// op (0 load, 1 store, 2 end), line address, store data, expected resp_data, writeback expected
// set is address bits 1:0; five addresses in set 0 force evictions
0 0001 0000000000000000 0001fffe0001fffe 0
1 0005 1111111111111111 1111111111111111 0
0 0005 0000000000000000 1111111111111111 0
1 0000 a0a0a0a0a0a0a0a0 a0a0a0a0a0a0a0a0 0
1 0004 a4a4a4a4a4a4a4a4 a4a4a4a4a4a4a4a4 0
1 0008 a8a8a8a8a8a8a8a8 a8a8a8a8a8a8a8a8 0
1 000c acacacacacacacac acacacacacacacac 0
1 0010 b0b0b0b0b0b0b0b0 b0b0b0b0b0b0b0b0 1
0 0000 0000000000000000 a0a0a0a0a0a0a0a0 1
0 0004 0000000000000000 a4a4a4a4a4a4a4a4 1
0 0008 0000000000000000 a8a8a8a8a8a8a8a8 1
0 000c 0000000000000000 acacacacacacacac 1
0 0010 0000000000000000 b0b0b0b0b0b0b0b0 0
0 000c 0000000000000000 acacacacacacacac 0
1 000c c0c0c0c0c0c0c0c0 c0c0c0c0c0c0c0c0 0
0 0014 0000000000000000 0014ffeb0014ffeb 0
0 0001 0000000000000000 0001fffe0001fffe 0
0 0000 0000000000000000 a0a0a0a0a0a0a0a0 0
0 000c 0000000000000000 c0c0c0c0c0c0c0c0 0
2 0000 0000000000000000 0000000000000000 0
